// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := mem_stage_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+src
src/mem_stage_pkg.sv
src/exe_mem_reg.sv
src/data_mem.sv
src/mem_wb_reg.sv
src/wb_select.sv
src/mem_stage_top.sv
testbench/mem_stage_sva.sv
testbench/mem_stage_tb.sv

// ==== src/data_mem.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module data_mem (
    input  logic                 clk,
    input  logic [`MEM_XLEN-1:0] mem_addr,
    input  logic [`MEM_XLEN-1:0] write_data,
    input  logic [`MEM_XLEN-1:0] write_mask,
    input  logic                 rd_en,
    output logic [`MEM_XLEN-1:0] rd_data
);

    localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);

    logic [`MEM_XLEN-1:0] mem [`MEM_DEPTH_WORDS];
    logic [IDX_W-1:0]     word_idx;
    logic [`MEM_XLEN-1:0] merged;

    // Byte address to word index, bits above the array are dropped
    assign word_idx = mem_addr[IDX_W+1:2];

    // Keep old bits where the mask is 1, take new data where it is 0
    assign merged = (mem[word_idx] & write_mask) | (write_data & ~write_mask);

    // An all-ones mask rewrites the same word, so no write enable needed
    always_ff @(posedge clk) begin
        mem[word_idx] <= merged;
    end

    // Registered read, returns the contents from before a same-edge write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[word_idx];
        end
    end

endmodule

// ==== src/exe_mem_reg.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module exe_mem_reg (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    exe_alu_out,
    input  logic [`MEM_REG_AW-1:0]  exe_write_addr,
    input  mem_stage_pkg::funct3_e  exe_funct3,
    input  logic [`MEM_XLEN-1:0]    exe_pc,
    input  logic [`MEM_XLEN-1:0]    exe_store_data,
    input  logic                    exe_rd_src,
    input  logic                    exe_mem_to_reg,
    input  logic                    exe_mem_write,
    input  logic                    exe_mem_read,
    input  logic                    exe_reg_write,
    output logic [`MEM_XLEN-1:0]    mem_alu_out,
    output logic [`MEM_REG_AW-1:0]  mem_write_addr,
    output mem_stage_pkg::funct3_e  mem_funct3,
    output logic [`MEM_XLEN-1:0]    mem_pc,
    output logic [`MEM_XLEN-1:0]    mem_store_data,
    output logic [`MEM_XLEN-1:0]    mem_write_mask,
    output logic                    mem_read,
    output logic                    mem_reg_write,
    output mem_stage_pkg::wb_src_e  mem_wb_src
);
    import mem_stage_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_alu_out    <= '0;
            mem_write_addr <= '0;
            mem_funct3     <= F3_B;
            mem_pc         <= '0;
            mem_store_data <= '0;
            mem_write_mask <= '1;
            mem_read       <= 1'b0;
            mem_reg_write  <= 1'b0;
            mem_wb_src     <= WB_ALU;
        end else begin
            // Mask is active low, a 0 bit gets written
            if (exe_mem_write) begin
                case (exe_funct3)
                    F3_B: begin
                        case (exe_alu_out[1:0])
                            2'd0: begin
                                mem_write_mask <= 32'hffff_ff00;
                                mem_store_data <= {24'd0, exe_store_data[7:0]};
                            end
                            2'd1: begin
                                mem_write_mask <= 32'hffff_00ff;
                                mem_store_data <= {16'd0, exe_store_data[7:0], 8'd0};
                            end
                            2'd2: begin
                                mem_write_mask <= 32'hff00_ffff;
                                mem_store_data <= {8'd0, exe_store_data[7:0], 16'd0};
                            end
                            default: begin
                                mem_write_mask <= 32'h00ff_ffff;
                                mem_store_data <= {exe_store_data[7:0], 24'd0};
                            end
                        endcase
                    end
                    F3_H: begin
                        // Halfword select is address bit 1, bit 0 is ignored
                        if (exe_alu_out[1]) begin
                            mem_write_mask <= 32'h0000_ffff;
                            mem_store_data <= {exe_store_data[15:0], 16'd0};
                        end else begin
                            mem_write_mask <= 32'hffff_0000;
                            mem_store_data <= {16'd0, exe_store_data[15:0]};
                        end
                    end
                    default: begin
                        mem_write_mask <= '0;
                        mem_store_data <= exe_store_data;
                    end
                endcase
            end else begin
                mem_write_mask <= '1;
                mem_store_data <= exe_store_data;
            end

            // Load wins over link when both are set
            if (exe_mem_to_reg) begin
                mem_wb_src <= WB_LOAD;
            end else if (exe_rd_src) begin
                mem_wb_src <= WB_LINK;
            end else begin
                mem_wb_src <= WB_ALU;
            end

            mem_alu_out    <= exe_alu_out;
            mem_write_addr <= exe_write_addr;
            mem_funct3     <= exe_funct3;
            mem_pc         <= exe_pc;
            mem_read       <= exe_mem_read;
            mem_reg_write  <= exe_reg_write;
        end
    end

endmodule

// ==== src/mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Width of the data path and of addresses
`define MEM_XLEN 32

// Width of a register file index
`define MEM_REG_AW 5

// Size of the data memory in 32-bit words
// The word index starts at address bit 2
`define MEM_DEPTH_WORDS 256

`endif

// ==== src/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // RV32 load and store funct3 codes
    // Stores reuse the byte, half and word codes of the signed loads
    typedef enum logic [2:0] {
        F3_B  = 3'd0,
        F3_H  = 3'd1,
        F3_W  = 3'd2,
        F3_BU = 3'd4,
        F3_HU = 3'd5
    } funct3_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        // Return address pc+4 for jal and jalr
        WB_LINK = 2'd2
    } wb_src_e;

endpackage

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_stage_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    exe_alu_out,
    input  logic [`MEM_REG_AW-1:0]  exe_write_addr,
    input  mem_stage_pkg::funct3_e  exe_funct3,
    input  logic [`MEM_XLEN-1:0]    exe_pc,
    input  logic [`MEM_XLEN-1:0]    exe_store_data,
    input  logic                    exe_rd_src,
    input  logic                    exe_mem_to_reg,
    input  logic                    exe_mem_write,
    input  logic                    exe_mem_read,
    input  logic                    exe_reg_write,
    output logic                    wb_reg_write,
    output logic [`MEM_REG_AW-1:0]  wb_write_addr,
    output logic [`MEM_XLEN-1:0]    wb_write_data
);
    import mem_stage_pkg::*;

    // Memory stage outputs
    logic [`MEM_XLEN-1:0]   mem_alu_out;
    logic [`MEM_REG_AW-1:0] mem_write_addr;
    funct3_e                mem_funct3;
    logic [`MEM_XLEN-1:0]   mem_pc;
    logic [`MEM_XLEN-1:0]   mem_store_data;
    logic [`MEM_XLEN-1:0]   mem_write_mask;
    logic                   mem_read;
    logic                   mem_reg_write;
    wb_src_e                mem_wb_src;

    // Write-back stage values
    logic [`MEM_XLEN-1:0]   rd_data;
    logic [`MEM_XLEN-1:0]   wb_alu_out;
    logic [`MEM_XLEN-1:0]   wb_pc;
    funct3_e                wb_funct3;
    logic [1:0]             wb_byte_off;
    wb_src_e                wb_src;

    exe_mem_reg u_exe_mem_reg (
        .clk            (clk),
        .reset          (reset),
        .exe_alu_out    (exe_alu_out),
        .exe_write_addr (exe_write_addr),
        .exe_funct3     (exe_funct3),
        .exe_pc         (exe_pc),
        .exe_store_data (exe_store_data),
        .exe_rd_src     (exe_rd_src),
        .exe_mem_to_reg (exe_mem_to_reg),
        .exe_mem_write  (exe_mem_write),
        .exe_mem_read   (exe_mem_read),
        .exe_reg_write  (exe_reg_write),
        .mem_alu_out    (mem_alu_out),
        .mem_write_addr (mem_write_addr),
        .mem_funct3     (mem_funct3),
        .mem_pc         (mem_pc),
        .mem_store_data (mem_store_data),
        .mem_write_mask (mem_write_mask),
        .mem_read       (mem_read),
        .mem_reg_write  (mem_reg_write),
        .mem_wb_src     (mem_wb_src)
    );

    // Memory and MEM/WB register work in the same cycle
    data_mem u_data_mem (
        .clk        (clk),
        .mem_addr   (mem_alu_out),
        .write_data (mem_store_data),
        .write_mask (mem_write_mask),
        .rd_en      (mem_read),
        .rd_data    (rd_data)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk            (clk),
        .reset          (reset),
        .mem_alu_out    (mem_alu_out),
        .mem_pc         (mem_pc),
        .mem_funct3     (mem_funct3),
        .mem_write_addr (mem_write_addr),
        .mem_reg_write  (mem_reg_write),
        .mem_wb_src     (mem_wb_src),
        .wb_alu_out     (wb_alu_out),
        .wb_pc          (wb_pc),
        .wb_funct3      (wb_funct3),
        .wb_byte_off    (wb_byte_off),
        .wb_write_addr  (wb_write_addr),
        .wb_reg_write   (wb_reg_write),
        .wb_src         (wb_src)
    );

    wb_select u_wb_select (
        .rd_data       (rd_data),
        .wb_alu_out    (wb_alu_out),
        .wb_pc         (wb_pc),
        .wb_funct3     (wb_funct3),
        .wb_byte_off   (wb_byte_off),
        .wb_src        (wb_src),
        .wb_write_data (wb_write_data)
    );

endmodule

// ==== src/mem_wb_reg.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_wb_reg (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    mem_alu_out,
    input  logic [`MEM_XLEN-1:0]    mem_pc,
    input  mem_stage_pkg::funct3_e  mem_funct3,
    input  logic [`MEM_REG_AW-1:0]  mem_write_addr,
    input  logic                    mem_reg_write,
    input  mem_stage_pkg::wb_src_e  mem_wb_src,
    output logic [`MEM_XLEN-1:0]    wb_alu_out,
    output logic [`MEM_XLEN-1:0]    wb_pc,
    output mem_stage_pkg::funct3_e  wb_funct3,
    output logic [1:0]              wb_byte_off,
    output logic [`MEM_REG_AW-1:0]  wb_write_addr,
    output logic                    wb_reg_write,
    output mem_stage_pkg::wb_src_e  wb_src
);
    import mem_stage_pkg::*;

    // Runs alongside the memory read so both land in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_alu_out    <= '0;
            wb_pc         <= '0;
            wb_funct3     <= F3_B;
            wb_byte_off   <= 2'd0;
            wb_write_addr <= '0;
            wb_reg_write  <= 1'b0;
            wb_src        <= WB_ALU;
        end else begin
            wb_alu_out    <= mem_alu_out;
            wb_pc         <= mem_pc;
            wb_funct3     <= mem_funct3;
            // Low address bits pick the byte lane of the loaded word
            wb_byte_off   <= mem_alu_out[1:0];
            wb_write_addr <= mem_write_addr;
            wb_reg_write  <= mem_reg_write;
            wb_src        <= mem_wb_src;
        end
    end

endmodule

// ==== src/wb_select.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module wb_select (
    input  logic [`MEM_XLEN-1:0]    rd_data,
    input  logic [`MEM_XLEN-1:0]    wb_alu_out,
    input  logic [`MEM_XLEN-1:0]    wb_pc,
    input  mem_stage_pkg::funct3_e  wb_funct3,
    input  logic [1:0]              wb_byte_off,
    input  mem_stage_pkg::wb_src_e  wb_src,
    output logic [`MEM_XLEN-1:0]    wb_write_data
);
    import mem_stage_pkg::*;

    logic [`MEM_XLEN-1:0] shifted;
    logic [`MEM_XLEN-1:0] load_val;

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = rd_data >> {wb_byte_off, 3'b000};

    always_comb begin
        case (wb_funct3)
            F3_B: begin
                load_val = {{24{shifted[7]}}, shifted[7:0]};
            end
            F3_H: begin
                load_val = {{16{shifted[15]}}, shifted[15:0]};
            end
            F3_BU: begin
                load_val = {24'd0, shifted[7:0]};
            end
            F3_HU: begin
                load_val = {16'd0, shifted[15:0]};
            end
            default: begin
                // LW takes the whole word as read
                load_val = rd_data;
            end
        endcase
    end

    always_comb begin
        case (wb_src)
            WB_LOAD: begin
                wb_write_data = load_val;
            end
            WB_LINK: begin
                wb_write_data = wb_pc + 32'd4;
            end
            default: begin
                wb_write_data = wb_alu_out;
            end
        endcase
    end

endmodule

// ==== testbench/mem_stage_sva.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_stage_sva (
    input logic                 clk,
    input logic                 reset,
    input logic                 exe_mem_write,
    input logic [`MEM_XLEN-1:0] mem_write_mask,
    input logic                 mem_reg_write
);

    // True when each byte lane of the mask is all zeros or all ones
    function automatic logic bytes_whole(input logic [`MEM_XLEN-1:0] mask);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `MEM_XLEN / 8; i++) begin
            if (mask[8*i +: 8] != 8'h00 && mask[8*i +: 8] != 8'hff) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    no_store_mask: assert property (@(posedge clk) disable iff (reset)
        !exe_mem_write |=> mem_write_mask == '1)
        else $error("write mask not all ones after a cycle without a store");

    reset_reg_write: assert property (@(posedge clk) reset |=> !mem_reg_write)
        else $error("mem_reg_write high while reset is asserted");

    whole_byte_mask: assert property (@(posedge clk) disable iff (reset)
        bytes_whole(mem_write_mask))
        else $error("write mask has a partial byte lane");

endmodule

bind exe_mem_reg mem_stage_sva u_sva (
    .clk            (clk),
    .reset          (reset),
    .exe_mem_write  (exe_mem_write),
    .mem_write_mask (mem_write_mask),
    .mem_reg_write  (mem_reg_write)
);

// ==== testbench/mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int IDX_W        = $clog2(`MEM_DEPTH_WORDS);
    localparam int RESET_CYCLES = 8;
    localparam int DIRECTED_OPS = 50;
    localparam int RANDOM_OPS   = 200;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * (DIRECTED_OPS + RANDOM_OPS) + 50;

    typedef struct packed {
        int                     stamp;
        logic                   we;
        logic [`MEM_REG_AW-1:0] addr;
        logic [`MEM_XLEN-1:0]   data;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`MEM_XLEN-1:0]   exe_alu_out;
    logic [`MEM_REG_AW-1:0] exe_write_addr;
    funct3_e                exe_funct3;
    logic [`MEM_XLEN-1:0]   exe_pc;
    logic [`MEM_XLEN-1:0]   exe_store_data;
    logic                   exe_rd_src;
    logic                   exe_mem_to_reg;
    logic                   exe_mem_write;
    logic                   exe_mem_read;
    logic                   exe_reg_write;
    logic                   wb_reg_write;
    logic [`MEM_REG_AW-1:0] wb_write_addr;
    logic [`MEM_XLEN-1:0]   wb_write_data;

    // Model memory updated in program order at issue
    logic [`MEM_XLEN-1:0] mirror [`MEM_DEPTH_WORDS];
    expect_t              exp_q[$];
    expect_t              head;
    int                   cycles = 0;
    int                   err_count = 0;
    int                   check_count = 0;
    int                   test_count = 0;
    int                   err_base = 0;
    int                   check_base = 0;
    funct3_e              store_codes [3] = '{F3_B, F3_H, F3_W};
    funct3_e              load_codes [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};

    mem_stage_top dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Applies a store to the model, then returns the write-back value
    function automatic logic [`MEM_XLEN-1:0] expected_wb(
        input logic                 wr,
        input logic                 to_reg,
        input logic                 link,
        input funct3_e              f3,
        input logic [`MEM_XLEN-1:0] alu,
        input logic [`MEM_XLEN-1:0] sdata,
        input logic [`MEM_XLEN-1:0] pc
    );
        logic [IDX_W-1:0]     idx;
        logic [`MEM_XLEN-1:0] word;
        logic [`MEM_XLEN-1:0] lane;
        int                   off;
        int                   hoff;
        idx  = alu[IDX_W+1:2];
        word = mirror[idx];
        off  = int'(alu[1:0]);
        hoff = 16 * int'(alu[1]);
        if (wr) begin
            case (f3)
                F3_B: begin
                    word[8*off +: 8] = sdata[7:0];
                end
                F3_H: begin
                    word[hoff +: 16] = sdata[15:0];
                end
                default: begin
                    word = sdata;
                end
            endcase
            mirror[idx] = word;
        end
        if (to_reg) begin
            lane = word >> (8 * off);
            case (f3)
                F3_B: return {{24{lane[7]}}, lane[7:0]};
                F3_H: return {{16{lane[15]}}, lane[15:0]};
                F3_BU: return {24'd0, lane[7:0]};
                F3_HU: return {16'd0, lane[15:0]};
                default: return word;
            endcase
        end
        if (link) begin
            return pc + 32'd4;
        end
        return alu;
    endfunction

    task automatic check_data(input logic [`MEM_XLEN-1:0] exp, input logic [`MEM_XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch wb_write_data: expected %h, got %h at cycle %0d", exp, act, cycles);
        end
    endtask

    task automatic check_addr(input logic [`MEM_REG_AW-1:0] exp,
                              input logic [`MEM_REG_AW-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch wb_write_addr: expected %h, got %h at cycle %0d", exp, act, cycles);
        end
    endtask

    task automatic check_we(input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch wb_reg_write: expected %h, got %h at cycle %0d", exp, act, cycles);
        end
    endtask

    // Result of an op issued at edge k is valid after edge k+2
    always @(negedge clk) begin
        if (!reset && exp_q.size() != 0 && exp_q[0].stamp + 3 == cycles) begin
            head = exp_q.pop_front();
            check_we(head.we, wb_reg_write);
            check_addr(head.addr, wb_write_addr);
            if (head.we) begin
                check_data(head.data, wb_write_data);
            end
        end else begin
            // No write-back during reset or in an idle slot
            check_we(1'b0, wb_reg_write);
        end
    end

    task automatic issue(
        input logic                   track,
        input logic                   wr,
        input logic                   to_reg,
        input logic                   link,
        input logic                   we,
        input funct3_e                f3,
        input logic [`MEM_XLEN-1:0]   alu,
        input logic [`MEM_XLEN-1:0]   sdata,
        input logic [`MEM_XLEN-1:0]   pc,
        input logic [`MEM_REG_AW-1:0] rd
    );
        expect_t e;
        @(posedge clk);
        exe_alu_out    <= alu;
        exe_write_addr <= rd;
        exe_funct3     <= f3;
        exe_pc         <= pc;
        exe_store_data <= sdata;
        exe_rd_src     <= link;
        exe_mem_to_reg <= to_reg;
        exe_mem_write  <= wr;
        exe_mem_read   <= to_reg;
        exe_reg_write  <= we;
        if (track) begin
            e.stamp = cycles;
            e.we    = we;
            e.addr  = rd;
            e.data  = expected_wb(wr, to_reg, link, f3, alu, sdata, pc);
            exp_q.push_back(e);
        end
    endtask

    task automatic store_op(input funct3_e f3, input logic [31:0] addr, input logic [31:0] data);
        issue(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, f3, addr, data, 32'd0, 5'd0);
    endtask

    task automatic load_op(input funct3_e f3, input logic [31:0] addr, input logic [4:0] rd);
        issue(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, f3, addr, 32'd0, 32'd0, rd);
    endtask

    task automatic alu_op(input logic [31:0] val, input logic [4:0] rd, input logic we);
        issue(1'b1, 1'b0, 1'b0, 1'b0, we, F3_W, val, 32'd0, 32'd0, rd);
    endtask

    task automatic link_op(input logic [31:0] pc, input logic [4:0] rd);
        issue(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, F3_W, 32'd0, 32'd0, pc, rd);
    endtask

    // Idles the inputs until every tracked op is checked
    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            issue(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, F3_B, 32'd0, 32'd0, 32'd0, 5'd0);
        end
        test_count++;
        $display("Test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - check_base, err_count - err_base);
        check_base = check_count;
        err_base   = err_count;
    endtask

    initial begin
        int                   n;
        int                   pick;
        int                   w;
        int                   o;
        funct3_e              f3;
        logic [`MEM_XLEN-1:0] a;
        void'($urandom(32'ha3f7_1195));
        reset          = 1'b1;
        exe_alu_out    = '0;
        exe_write_addr = '0;
        exe_funct3     = F3_B;
        exe_pc         = '0;
        exe_store_data = '0;
        exe_rd_src     = 1'b0;
        exe_mem_to_reg = 1'b0;
        exe_mem_write  = 1'b0;
        exe_mem_read   = 1'b0;
        exe_reg_write  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        alu_op(32'd0, 5'd0, 1'b0);
        alu_op(32'd0, 5'd0, 1'b0);
        finish_test("reset_idle");

        store_op(F3_W, 32'h200, 32'hdead_beef);
        load_op(F3_W, 32'h200, 5'd5);
        alu_op(32'h1234_5678, 5'd6, 1'b1);
        link_op(32'h0000_0ffc, 5'd1);
        finish_test("word_alu_link");

        for (int i = 0; i < 4; i++) begin
            store_op(F3_W, 32'h210, 32'h1122_3344);
            store_op(F3_B, 32'h210 + i, 32'hffff_ffc0 + i);
            load_op(F3_W, 32'h210, 5'd7);
        end
        finish_test("byte_stores");

        store_op(F3_W, 32'h220, 32'h0000_0000);
        store_op(F3_H, 32'h220, 32'h1234_8a5c);
        store_op(F3_H, 32'h222, 32'hffff_7e01);
        load_op(F3_H, 32'h220, 5'd8);
        load_op(F3_H, 32'h222, 5'd9);
        load_op(F3_HU, 32'h220, 5'd10);
        load_op(F3_HU, 32'h222, 5'd11);
        finish_test("half_stores");

        // Every byte has its top bit set
        store_op(F3_W, 32'h230, 32'h8093_a5f1);
        for (int i = 0; i < 4; i++) begin
            load_op(F3_B, 32'h230 + i, 5'd12);
        end
        for (int i = 0; i < 4; i++) begin
            load_op(F3_BU, 32'h230 + i, 5'd13);
        end
        finish_test("byte_loads");

        // Known contents for the 16-word random window
        for (int i = 0; i < 16; i++) begin
            a = 4 * i;
            store_op(F3_W, a, (a * 32'h9e37_79b9) ^ 32'hc3a5_0f96);
        end
        n = 0;
        while (n < RANDOM_OPS) begin
            pick = $urandom_range(9, 0);
            w    = $urandom_range(15, 0);
            o    = $urandom_range(3, 0);
            if (pick <= 2 || pick == 9) begin
                f3 = store_codes[$urandom_range(2, 0)];
            end else begin
                f3 = load_codes[$urandom_range(4, 0)];
            end
            if (f3 == F3_W) begin
                o = 0;
            end else if (f3 == F3_H || f3 == F3_HU) begin
                o = o & 2;
            end
            a = 4 * w + o;
            if (pick <= 2) begin
                store_op(f3, a, $urandom());
            end else if (pick <= 5) begin
                load_op(f3, a, 5'($urandom_range(31, 1)));
            end else if (pick <= 7) begin
                alu_op($urandom(), 5'($urandom_range(31, 1)), 1'($urandom_range(1, 0)));
            end else if (pick == 8) begin
                link_op($urandom_range(65535, 0) << 2, 5'd1);
            end else begin
                // Store then load of the same word back to back
                store_op(f3, a, $urandom());
                load_op(F3_W, 4 * w, 5'($urandom_range(31, 1)));
                n++;
            end
            n++;
        end
        finish_test("random_mix");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
